// ==== vga_defs.svh ====
// VGA scan-out constants.
// Fixed 800x600 at 72 Hz timing with a 50 MHz pixel clock, and the
// frame-buffer geometry for 400x300 bytes with a 512-byte row pitch.

`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

// Horizontal timing, in pixel clocks.
`define VGA_H_VISIBLE 800   // Visible columns.
`define VGA_H_FRONT   56    // Porch between sync and the first visible column.
`define VGA_H_SYNC    120   // Sync pulse width.
`define VGA_H_WHOLE   1040  // Whole line.

// Vertical timing, in lines.
`define VGA_V_VISIBLE 600   // Visible rows.
`define VGA_V_FRONT   37    // Porch between sync and the first visible row.
`define VGA_V_SYNC    6     // Sync pulse height.
`define VGA_V_WHOLE   666   // Whole frame.

// Counter width, wide enough for VGA_H_WHOLE.
`define VGA_CNT_WIDTH 11

// Frame buffer.
// Each row of 400 bytes starts on a 512-byte boundary, so the byte
// address is {row, column} with the column in the low bits.
`define VGA_ROW_SHIFT  9       // Log2 of the row pitch.
`define VGA_ADDR_WIDTH 18      // Byte address width.
`define VGA_FB_DEPTH   153600  // 300 rows of 512 bytes.

`endif

// ==== vga_pkg.sv ====
// VGA shared types.
// Wishbone request and response, frame-buffer port, scan position and
// the 9-bit output colour, all as packed structs.

`default_nettype none

`include "vga_defs.svh"

package vga_pkg;

	// Wishbone classic request from the host.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`VGA_ADDR_WIDTH-1:0] adr;
		logic [7:0] dat;
	} wb_req_t;

	// Wishbone classic response to the host.
	typedef struct packed {
		logic ack;
		logic [7:0] dat;
	} wb_rsp_t;

	// Read/write access on frame-buffer port A.
	typedef struct packed {
		logic en;
		logic we;
		logic [`VGA_ADDR_WIDTH-1:0] addr;
		logic [7:0] wdata;
	} fb_port_t;

	// Scan position. x and y count from the visible origin.
	typedef struct packed {
		logic [`VGA_CNT_WIDTH-1:0] x;
		logic [`VGA_CNT_WIDTH-1:0] y;
		logic visible;
		logic hsync_n;
		logic vsync_n;
	} scan_pos_t;

	// Output colour, blue in the top bits.
	typedef struct packed {
		logic [2:0] blue;
		logic [2:0] green;
		logic [2:0] red;
	} rgb9_t;

endpackage

`default_nettype wire

// ==== vga_timing.sv ====
// VGA timing generator.
// Column and row counters for 800x600 at 72 Hz. Produces the scan
// position relative to the visible origin, the visible flag and raw syncs.

`timescale 1ns/1ns
`default_nettype none

`include "vga_defs.svh"

module vga_timing (
	input wire clk50M,
	input wire rst,
	output vga_pkg::scan_pos_t pos
);

	// Sync comes first in the line, then the porch, then the visible part.
	localparam logic [`VGA_CNT_WIDTH-1:0] H_LAST =
		`VGA_CNT_WIDTH'(`VGA_H_WHOLE - 1);
	localparam logic [`VGA_CNT_WIDTH-1:0] V_LAST =
		`VGA_CNT_WIDTH'(`VGA_V_WHOLE - 1);
	localparam logic [`VGA_CNT_WIDTH-1:0] H_SYNC_END =
		`VGA_CNT_WIDTH'(`VGA_H_SYNC);
	localparam logic [`VGA_CNT_WIDTH-1:0] V_SYNC_END =
		`VGA_CNT_WIDTH'(`VGA_V_SYNC);
	localparam logic [`VGA_CNT_WIDTH-1:0] H_START =
		`VGA_CNT_WIDTH'(`VGA_H_SYNC + `VGA_H_FRONT);
	localparam logic [`VGA_CNT_WIDTH-1:0] V_START =
		`VGA_CNT_WIDTH'(`VGA_V_SYNC + `VGA_V_FRONT);
	localparam logic [`VGA_CNT_WIDTH-1:0] H_END =
		`VGA_CNT_WIDTH'(`VGA_H_SYNC + `VGA_H_FRONT + `VGA_H_VISIBLE);
	localparam logic [`VGA_CNT_WIDTH-1:0] V_END =
		`VGA_CNT_WIDTH'(`VGA_V_SYNC + `VGA_V_FRONT + `VGA_V_VISIBLE);

	logic [`VGA_CNT_WIDTH-1:0] h_cnt;  // Column within the line.
	logic [`VGA_CNT_WIDTH-1:0] v_cnt;  // Line within the frame.
	logic h_last;
	logic v_last;
	logic h_vis;
	logic v_vis;

	assign h_last = (h_cnt == H_LAST);
	assign v_last = (v_cnt == V_LAST);
	assign h_vis = (h_cnt >= H_START) && (h_cnt < H_END);
	assign v_vis = (v_cnt >= V_START) && (v_cnt < V_END);

	always_ff @(posedge clk50M) begin
		if (rst) begin
			h_cnt <= '0;  // Starts inside both sync pulses.
			v_cnt <= '0;
		end else if (h_last) begin
			h_cnt <= '0;
			if (v_last) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// Position wraps outside the visible area; only valid with visible.
	always_comb begin
		pos.x = h_cnt - H_START;
		pos.y = v_cnt - V_START;
		pos.visible = h_vis && v_vis;
		pos.hsync_n = (h_cnt >= H_SYNC_END);  // Low for the first 120 columns.
		pos.vsync_n = (v_cnt >= V_SYNC_END);  // Low for the first 6 lines.
	end

	a_h_range: assert property (@(posedge clk50M) disable iff (rst)
		h_cnt < `VGA_CNT_WIDTH'(`VGA_H_WHOLE))
		else $error("column counter reached the line length");

	// Row moves only on the cycle after the last column.
	a_v_step: assert property (@(posedge clk50M) disable iff (rst)
		!$stable(v_cnt) |-> $past(h_last))
		else $error("row counter moved without a column wrap");

endmodule

`default_nettype wire

// ==== vga_frame_ram.sv ====
// VGA frame buffer.
// True dual-port byte array. Port A reads and writes for the host,
// port B reads every cycle for scan-out. Both ports have one cycle latency.

`timescale 1ns/1ns
`default_nettype none

`include "vga_defs.svh"

module vga_frame_ram (
	input wire clk50M,
	input wire vga_pkg::fb_port_t a,
	output logic [7:0] a_rdata,
	input wire [`VGA_ADDR_WIDTH-1:0] b_addr,
	output logic [7:0] b_rdata
);

	logic [7:0] mem [0:`VGA_FB_DEPTH-1];  // One RGB332 pixel per byte.

	// Port A, host side.
	always_ff @(posedge clk50M) begin
		if (a.en) begin
			if (a.we) begin
				mem[a.addr] <= a.wdata;
			end
			a_rdata <= mem[a.addr];  // Old contents on a write.
		end
	end

	// Port B, scan side.
	always_ff @(posedge clk50M) begin
		b_rdata <= mem[b_addr];
	end

	// Callers keep both addresses inside the array.
	a_a_range: assert property (@(posedge clk50M)
		a.en |-> a.addr < `VGA_ADDR_WIDTH'(`VGA_FB_DEPTH))
		else $error("port A access beyond the frame buffer");

	a_b_range: assert property (@(posedge clk50M)
		b_addr < `VGA_ADDR_WIDTH'(`VGA_FB_DEPTH))
		else $error("port B read beyond the frame buffer");

endmodule

`default_nettype wire

// ==== vga_wb_port.sv ====
// VGA host port.
// Wishbone classic slave onto frame-buffer port A. Every access is
// acknowledged one cycle after it is sampled; out-of-range ones are dropped.

`timescale 1ns/1ns
`default_nettype none

`include "vga_defs.svh"

module vga_wb_port (
	input wire clk50M,
	input wire rst,
	input wire vga_pkg::wb_req_t wb_i,
	output vga_pkg::wb_rsp_t wb_o,
	output vga_pkg::fb_port_t fb,
	input wire [7:0] fb_rdata
);

	localparam logic [`VGA_ADDR_WIDTH-1:0] FB_LIMIT =
		`VGA_ADDR_WIDTH'(`VGA_FB_DEPTH);

	logic req;       // Fresh request in this cycle.
	logic in_range;
	logic ack;
	logic oor_q;     // Pending access was beyond the buffer.

	// A held request is not taken again while ack is high.
	assign req = wb_i.cyc && wb_i.stb && !ack;
	assign in_range = (wb_i.adr < FB_LIMIT);

	// RAM acts on the same edge that raises ack.
	always_comb begin
		fb.en = req && in_range;
		fb.we = wb_i.we;
		fb.addr = wb_i.adr;
		fb.wdata = wb_i.dat;
	end

	always_ff @(posedge clk50M) begin
		if (rst) begin
			ack <= 1'b0;
			oor_q <= 1'b0;
		end else begin
			ack <= req;  // Single-cycle pulse.
			if (req) begin
				oor_q <= !in_range;
			end
		end
	end

	// RAM read byte lines up with ack.
	always_comb begin
		wb_o.ack = ack;
		wb_o.dat = oor_q ? 8'h00 : fb_rdata;
	end

	a_ack_pulse: assert property (@(posedge clk50M) disable iff (rst)
		ack |=> !ack)
		else $error("ack held for more than one cycle");

endmodule

`default_nettype wire

// ==== vga_pixel_out.sv ====
// VGA pixel stage.
// Reads the byte under the scan position with 2x2 doubling, expands
// RGB332 to 9 bits and delays syncs so colour and syncs leave together.

`timescale 1ns/1ns
`default_nettype none

`include "vga_defs.svh"

module vga_pixel_out (
	input wire clk50M,
	input wire rst,
	input wire vga_pkg::scan_pos_t pos,
	output logic [`VGA_ADDR_WIDTH-1:0] ram_addr,
	input wire [7:0] ram_data,
	output vga_pkg::rgb9_t color,
	output logic hsync,
	output logic vsync
);

	import vga_pkg::*;

	rgb9_t expanded;                          // Colour of the byte just read.
	logic [`VGA_ADDR_WIDTH-1:0] row_base;
	logic [`VGA_ADDR_WIDTH-1:0] col_off;
	logic vis_d1;
	logic vis_d2;
	logic hs_d1;
	logic vs_d1;

	// Halving x and y repeats each byte over a 2x2 block.
	assign row_base = `VGA_ADDR_WIDTH'(pos.y[`VGA_CNT_WIDTH-1:1]) << `VGA_ROW_SHIFT;
	assign col_off = `VGA_ADDR_WIDTH'(pos.x[`VGA_CNT_WIDTH-1:1]);
	assign ram_addr = pos.visible ? (row_base + col_off) : '0;  // Park at 0 in blanking.

	always_comb begin
		expanded.red = ram_data[7:5];
		expanded.green = ram_data[4:2];
		case (ram_data[1:0])
			2'd0: expanded.blue = 3'd0;
			2'd1: expanded.blue = 3'd2;
			2'd2: expanded.blue = 3'd5;
			default: expanded.blue = 3'd7;
		endcase
	end

	// Stage 1 covers the RAM read, stage 2 the colour register.
	always_ff @(posedge clk50M) begin
		if (rst) begin
			vis_d1 <= 1'b0;
			hs_d1 <= 1'b0;
			vs_d1 <= 1'b0;
			vis_d2 <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			color <= '0;
		end else begin
			vis_d1 <= pos.visible;
			hs_d1 <= pos.hsync_n;
			vs_d1 <= pos.vsync_n;
			vis_d2 <= vis_d1;
			hsync <= hs_d1;
			vsync <= vs_d1;
			color <= vis_d1 ? expanded : '0;  // Black outside the picture.
		end
	end

	a_blank: assert property (@(posedge clk50M) disable iff (rst)
		!vis_d2 |-> color == '0)
		else $error("colour driven during blanking");

endmodule

`default_nettype wire

// ==== vga_top.sv ====
// VGA scan-out subsystem.
// Host writes a 400x300 RGB332 frame buffer over Wishbone; the buffer
// is scanned out doubled to 800x600 at 72 Hz.

`timescale 1ns/1ns
`default_nettype none

`include "vga_defs.svh"

module vga_top (
	input wire clk50M,
	input wire rst,
	input wire vga_pkg::wb_req_t wb_i,
	output vga_pkg::wb_rsp_t wb_o,
	output vga_pkg::rgb9_t color,
	output logic hsync,
	output logic vsync
);

	import vga_pkg::*;

	fb_port_t fb_a;                          // Host access on port A.
	logic [7:0] fb_a_rdata;
	scan_pos_t pos;                          // Counter state to the pixel stage.
	logic [`VGA_ADDR_WIDTH-1:0] scan_addr;   // Port B read address.
	logic [7:0] scan_data;

	vga_wb_port u_wb_port (
		.clk50M   (clk50M),
		.rst      (rst),
		.wb_i     (wb_i),
		.wb_o     (wb_o),
		.fb       (fb_a),
		.fb_rdata (fb_a_rdata)
	);

	vga_frame_ram u_frame_ram (
		.clk50M  (clk50M),
		.a       (fb_a),
		.a_rdata (fb_a_rdata),
		.b_addr  (scan_addr),
		.b_rdata (scan_data)
	);

	vga_timing u_timing (
		.clk50M (clk50M),
		.rst    (rst),
		.pos    (pos)
	);

	vga_pixel_out u_pixel_out (
		.clk50M   (clk50M),
		.rst      (rst),
		.pos      (pos),
		.ram_addr (scan_addr),
		.ram_data (scan_data),
		.color    (color),
		.hsync    (hsync),
		.vsync    (vsync)
	);

endmodule

`default_nettype wire

// ==== tb_vga.sv ====
// Testbench for the VGA scan-out subsystem.
// Directed tests for reset, sync timing, Wishbone access, pixel placement,
// colour expansion and blanking against a byte model of the frame buffer.

`timescale 1ns/1ns
`default_nettype none

`include "vga_defs.svh"

module tb_vga;

	import vga_pkg::*;

	localparam int LINE = `VGA_H_WHOLE;
	localparam int FRAME = `VGA_H_WHOLE * `VGA_V_WHOLE;
	localparam int ACK_LIMIT = 16;
	localparam int ADDR_TOP = (1 << `VGA_ADDR_WIDTH) - 1;

	logic clk50M;
	logic rst;
	wb_req_t wb_i;
	wb_rsp_t wb_o;
	rgb9_t color;
	logic hsync;
	logic vsync;

	logic [7:0] fb_model [0:`VGA_FB_DEPTH-1];  // Mirror of every in-range write.
	logic [2:0] blue_level [0:3] = '{3'd0, 3'd2, 3'd5, 3'd7};
	int errors;
	int timeouts;
	int seed;
	logic aborted;

	vga_top dut (
		.clk50M (clk50M),
		.rst    (rst),
		.wb_i   (wb_i),
		.wb_o   (wb_o),
		.color  (color),
		.hsync  (hsync),
		.vsync  (vsync)
	);

	always #10 clk50M = ~clk50M;

	// Screen colour of one stored RGB332 byte.
	function automatic rgb9_t expand(input logic [7:0] pix);
		rgb9_t c;
		c.red = pix[7:5];
		c.green = pix[4:2];
		c.blue = blue_level[pix[1:0]];
		return c;
	endfunction

	function automatic logic [7:0] fill_byte(input logic [`VGA_ADDR_WIDTH-1:0] a);
		return a[7:0] ^ a[15:8] ^ {6'd0, a[17:16]} ^ 8'h5a;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected !== actual) begin
			errors++;
			$display("Error %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		aborted = 1'b1;
		timeouts++;
		$display("Timeout: %s did not happen in time", what);
	endtask

	// One Wishbone classic cycle; also checks that ack is a single pulse.
	task automatic wb_access(input logic we, input int adr, input logic [7:0] dat,
			output logic [7:0] rdata);
		int wait_cnt;
		wait_cnt = 0;
		rdata = 8'h00;
		wb_i.cyc = 1'b1;
		wb_i.stb = 1'b1;
		wb_i.we = we;
		wb_i.adr = `VGA_ADDR_WIDTH'(adr);
		wb_i.dat = dat;
		@(negedge clk50M);
		while (!wb_o.ack && wait_cnt < ACK_LIMIT) begin
			wait_cnt++;
			@(negedge clk50M);
		end
		if (!wb_o.ack) begin
			report_timeout("Wishbone ack");
		end else begin
			rdata = wb_o.dat;  // Valid together with ack.
		end
		wb_i.cyc = 1'b0;
		wb_i.stb = 1'b0;
		wb_i.we = 1'b0;
		@(negedge clk50M);
		check_value("ack width", 0, int'(wb_o.ack));
	endtask

	task automatic wb_write(input int adr, input logic [7:0] dat);
		logic [7:0] unused_rd;
		wb_access(1'b1, adr, dat, unused_rd);
		if (adr < `VGA_FB_DEPTH) begin
			fb_model[adr] = dat;
		end
	endtask

	task automatic wb_read(input int adr, output logic [7:0] dat);
		wb_access(1'b0, adr, 8'h00, dat);
	endtask

	// Counts samples up to the next rise, and how many of them were low.
	task automatic wait_sync_rise(input logic use_vsync, input int limit,
			output int cycles, output int low_cycles);
		logic prev;
		logic now_val;
		cycles = 0;
		low_cycles = 0;
		now_val = use_vsync ? vsync : hsync;
		do begin
			prev = now_val;
			@(negedge clk50M);
			now_val = use_vsync ? vsync : hsync;
			cycles++;
			if (!now_val) begin
				low_cycles++;
			end
		end while (!(now_val && !prev) && cycles < limit);
		if (!(now_val && !prev)) begin
			report_timeout(use_vsync ? "vsync rise" : "hsync rise");
		end
	endtask

	task automatic test_reset();
		repeat (3) begin
			@(negedge clk50M);
			check_value("reset color", 0, int'(color));
			check_value("reset ack", 0, int'(wb_o.ack));
		end
		rst = 1'b0;
		@(negedge clk50M);
		check_value("reset color", 0, int'(color));
		check_value("reset ack", 0, int'(wb_o.ack));
		check_value("reset hsync", 0, int'(hsync));  // Counters start inside sync.
		check_value("reset vsync", 0, int'(vsync));
	endtask

	task automatic test_sync();
		int cycles;
		int low;
		wait_sync_rise(1'b0, 2 * LINE, cycles, low);
		if (aborted) return;
		wait_sync_rise(1'b0, 2 * LINE, cycles, low);
		if (aborted) return;
		check_value("hsync period", LINE, cycles);
		check_value("hsync low", `VGA_H_SYNC, low);
		wait_sync_rise(1'b1, 2 * FRAME, cycles, low);
		if (aborted) return;
		wait_sync_rise(1'b1, 2 * FRAME, cycles, low);
		if (aborted) return;
		check_value("vsync period", FRAME, cycles);
		check_value("vsync low", `VGA_V_SYNC * LINE, low);
	endtask

	// Every displayed byte gets a value, so the whole frame can be predicted.
	task automatic fill_buffer();
		int a;
		for (int row = 0; row < `VGA_V_VISIBLE / 2; row++) begin
			for (int col = 0; col < `VGA_H_VISIBLE / 2; col++) begin
				a = (row << `VGA_ROW_SHIFT) + col;
				wb_write(a, fill_byte(`VGA_ADDR_WIDTH'(a)));
				if (aborted) return;
			end
		end
	endtask

	task automatic test_wb();
		logic [7:0] rdata;
		int addr [0:15];
		for (int i = 0; i < 16; i++) begin
			addr[i] = int'($unsigned($random(seed)) % `VGA_FB_DEPTH);
			wb_write(addr[i], 8'($random(seed)));
			if (aborted) return;
		end
		for (int i = 0; i < 16; i++) begin
			wb_read(addr[i], rdata);
			if (aborted) return;
			check_value("wb readback", int'(fb_model[addr[i]]), int'(rdata));
		end
		wb_write(`VGA_FB_DEPTH - 1, 8'h81);  // Known bytes where a wrapped address lands.
		wb_write(ADDR_TOP - `VGA_FB_DEPTH, 8'h7e);
		wb_write(`VGA_FB_DEPTH, 8'hc3);  // Beyond the buffer, dropped.
		wb_write(ADDR_TOP, 8'h3c);
		wb_read(`VGA_FB_DEPTH, rdata);
		check_value("oor read", 0, int'(rdata));
		wb_read(ADDR_TOP, rdata);
		check_value("oor read", 0, int'(rdata));
		wb_read(0, rdata);
		check_value("oor no alias", int'(fb_model[0]), int'(rdata));
		wb_read(`VGA_FB_DEPTH - 1, rdata);
		check_value("oor no alias", int'(fb_model[`VGA_FB_DEPTH-1]), int'(rdata));
		wb_read(ADDR_TOP - `VGA_FB_DEPTH, rdata);
		check_value("oor no alias", int'(fb_model[ADDR_TOP-`VGA_FB_DEPTH]), int'(rdata));
	endtask

	// Corners of rows 0 and 299, then every blue code with red and green at 0 and 7.
	task automatic write_marks();
		logic [7:0] colours [0:7] = '{8'h00, 8'h01, 8'h02, 8'h03, 8'he0, 8'h1c, 8'hff, 8'he3};
		int last_row;
		last_row = (`VGA_V_VISIBLE / 2 - 1) << `VGA_ROW_SHIFT;
		wb_write(0, 8'ha5);
		wb_write(`VGA_H_VISIBLE / 2 - 1, 8'h5a);
		wb_write(last_row, 8'h96);
		wb_write(last_row + `VGA_H_VISIBLE / 2 - 1, 8'h69);
		for (int i = 0; i < 8; i++) begin
			wb_write((150 << `VGA_ROW_SHIFT) + 200 + i, colours[i]);
		end
	endtask

	// One whole frame from a vsync rise, cycle by cycle.
	task automatic check_frame();
		int cycles;
		int low;
		int line_idx;
		int since_rise;
		int row;
		int col;
		logic prev_hs;
		rgb9_t expected;
		wait_sync_rise(1'b1, 2 * FRAME, cycles, low);
		if (aborted) return;
		line_idx = -1;  // Line 0 starts with the first hsync rise.
		since_rise = 0;
		prev_hs = hsync;
		for (int t = 0; t < FRAME; t++) begin
			@(negedge clk50M);
			if (hsync && !prev_hs) begin
				line_idx++;
				since_rise = 0;
			end else begin
				since_rise++;
			end
			prev_hs = hsync;
			row = line_idx - `VGA_V_FRONT;
			col = since_rise - `VGA_H_FRONT;
			if (row >= 0 && row < `VGA_V_VISIBLE && col >= 0 && col < `VGA_H_VISIBLE) begin
				expected = expand(fb_model[(row / 2) * (1 << `VGA_ROW_SHIFT) + col / 2]);
				check_value("pixel", int'(expected), int'(color));
			end else begin
				check_value("blank", 0, int'(color));
			end
		end
	endtask

	initial begin
		clk50M = 1'b0;
		rst = 1'b1;
		wb_i = '0;
		errors = 0;
		timeouts = 0;
		aborted = 1'b0;
		seed = 32'hb42e;
		test_reset();
		test_sync();
		if (!aborted) fill_buffer();
		if (!aborted) test_wb();
		if (!aborted) write_marks();
		if (!aborted) check_frame();
		$display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
vga_pkg.sv
vga_timing.sv
vga_frame_ram.sv
vga_wb_port.sv
vga_pixel_out.sv
vga_top.sv
tb_vga.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the VGA testbench with Verilator, runs it and checks the log.
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_vga \
	&& ./obj_dir/Vtb_vga > sim.log 2>&1 \
	|| echo "Build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -q "^Test OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
